// ==== dv/tb_vic_ext.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_vic_ext;

    localparam int MAX_VEC   = 256;
    localparam int SWEEP_LEN = 100;

    logic        clk_dot4x;
    logic        rst;
    logic        bus_strobe;
    logic        rw;
    logic [5:0]  addr;
    logic [7:0]  dbi;
    logic [7:0]  dbo;
    logic        rd_valid;
    logic [3:0]  pixel_color4;
    logic        half_bright;
    logic        active;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        hide_raster_lines;
    logic        show_raster_lines;
    logic        hires_enabled;
    logic [1:0]  hires_mode;
    logic [2:0]  hires_char_pixel_base;
    logic [3:0]  hires_matrix_base;
    logic [3:0]  hires_color_base;

    // vectors as loaded from the file
    logic [7:0]  vec_kind [MAX_VEC];
    logic [15:0] vec_a [MAX_VEC];
    logic [15:0] vec_b [MAX_VEC];
    logic [15:0] vec_c [MAX_VEC];
    logic [15:0] vec_d [MAX_VEC];
    int          vec_count;
    logic        loaded;

    // palette contents as written by the sweep setup
    logic [15:0] pal_model [32];
    logic [11:0] rgb_exp [SWEEP_LEN];
    int          seed;

    vic_ext_top #(.VRAM_AW(15), .PAL_ENTRIES_AW(5)) uut (
        .clk_dot4x             (clk_dot4x),
        .rst                   (rst),
        .bus_strobe            (bus_strobe),
        .rw                    (rw),
        .addr                  (addr),
        .dbi                   (dbi),
        .dbo                   (dbo),
        .rd_valid              (rd_valid),
        .pixel_color4          (pixel_color4),
        .half_bright           (half_bright),
        .active                (active),
        .red                   (red),
        .green                 (green),
        .blue                  (blue),
        .hide_raster_lines     (hide_raster_lines),
        .show_raster_lines     (show_raster_lines),
        .hires_enabled         (hires_enabled),
        .hires_mode            (hires_mode),
        .hires_char_pixel_base (hires_char_pixel_base),
        .hires_matrix_base     (hires_matrix_base),
        .hires_color_base      (hires_color_base)
    );

    always #4 clk_dot4x = ~clk_dot4x;

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] expv);
        assert (got === expv) else begin
            $display("[ERROR] t=%0t %s expected %0h got %0h", $time, name, expv, got);
            stop_with_failure();
        end
    endtask

    // rgb from a palette word, half bright halves each channel
    function automatic logic [11:0] expected_rgb(input logic [15:0] entry, input logic hb,
                                                 input logic act);
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        r = entry[15:12];
        g = entry[11:8];
        b = entry[7:4];
        if (hb) begin
            r = r >> 1;
            g = g >> 1;
            b = b >> 1;
        end
        return act ? {r, g, b} : 12'h000;
    endfunction

    task automatic load_vectors();
        int         fd;
        int         n;
        int         ch;
        logic [7:0] kc;
        logic [15:0] f1;
        logic [15:0] f2;
        logic [15:0] f3;
        logic [15:0] f4;
        fd = $fopen("dv/vic_ext_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/vic_ext_vectors.txt");
            stop_with_failure();
        end
        vec_count = 0;
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", kc);
            if (n == 1 && kc == "#") begin
                // comment runs to end of line
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (n == 1) begin
                f3 = 16'h0;
                f4 = 16'h0;
                if (kc == "P") begin
                    n = $fscanf(fd, " %h %h %h %h", f1, f2, f3, f4);
                end else begin
                    n = $fscanf(fd, " %h %h", f1, f2) + 2;
                end
                if (n != 4 || !(kc == "W" || kc == "R" || kc == "P") || vec_count >= MAX_VEC) begin
                    $display("vector file line %0d is malformed", vec_count);
                    stop_with_failure();
                end
                vec_kind[vec_count] = kc;
                vec_a[vec_count]    = f1;
                vec_b[vec_count]    = f2;
                vec_c[vec_count]    = f3;
                vec_d[vec_count]    = f4;
                vec_count++;
            end
        end
        $fclose(fd);
    endtask

    // starts and ends on a falling edge, 5 cycles per access
    task automatic bus_write(input logic [5:0] a, input logic [7:0] d);
        bus_strobe = 1'b1;
        rw         = 1'b0;
        addr       = a;
        dbi        = d;
        @(negedge clk_dot4x);
        bus_strobe = 1'b0;
        // mode registers land at the edge ending the strobe cycle
        if (a == 6'h31) begin
            check_val("hires_mode", 16'(hires_mode), 16'(d[6:5]));
            check_val("hires_enabled", 16'(hires_enabled), 16'(d[4]));
            check_val("hires_char_pixel_base", 16'(hires_char_pixel_base), 16'(d[2:0]));
        end else if (a == 6'h32) begin
            check_val("hires_color_base", 16'(hires_color_base), 16'(d[7:4]));
            check_val("hires_matrix_base", 16'(hires_matrix_base), 16'(d[3:0]));
        end
        repeat (4) @(negedge clk_dot4x);
    endtask

    task automatic bus_read(input logic [5:0] a, input logic [7:0] expv);
        int waited;
        bus_strobe = 1'b1;
        rw         = 1'b1;
        addr       = a;
        @(negedge clk_dot4x);
        bus_strobe = 1'b0;
        waited     = 0;
        while (!rd_valid && waited < 6) begin
            @(negedge clk_dot4x);
            waited++;
        end
        if (!rd_valid) begin
            $display("read of address %02h got no rd_valid within 6 cycles", a);
            stop_with_failure();
        end
        check_val("dbo", 16'(dbo), 16'(expv));
        repeat (3) @(negedge clk_dot4x);
    endtask

    // rgb shows up two cycles after the sample
    task automatic pixel_check(input logic [3:0] color, input logic hb, input logic act,
                               input logic [11:0] expv);
        pixel_color4 = color;
        half_bright  = hb;
        active       = act;
        repeat (2) @(negedge clk_dot4x);
        check_val("rgb", 16'({red, green, blue}), 16'(expv));
    endtask

    task automatic run_vectors();
        for (int i = 0; i < vec_count; i++) begin
            if (vec_kind[i] == "W") begin
                bus_write(vec_a[i][5:0], vec_b[i][7:0]);
            end else if (vec_kind[i] == "R") begin
                bus_read(vec_a[i][5:0], vec_b[i][7:0]);
            end else begin
                pixel_check(vec_a[i][3:0], vec_b[i][0], vec_c[i][0], vec_d[i][11:0]);
            end
        end
    endtask

    // overlay on, pointer 1 increments through every nibble of all entries
    task automatic fill_palette();
        int rnd;
        bus_write(6'h3f, 8'h21);
        bus_read(6'h3f, 8'h21);
        bus_write(6'h39, 8'h00);
        bus_write(6'h3b, 8'h00);
        for (int e = 0; e < 32; e++) begin
            for (int n = 0; n < 4; n++) begin
                rnd = $random(seed);
                case (n)
                    0:       pal_model[e][15:12] = rnd[3:0];
                    1:       pal_model[e][11:8]  = rnd[3:0];
                    2:       pal_model[e][7:4]   = rnd[3:0];
                    default: pal_model[e][3:0]   = rnd[3:0];
                endcase
                bus_write(6'h3a, rnd[7:0]);
            end
        end
        // 128 steps from lo 0
        bus_read(6'h3b, 8'h80);
    endtask

    task automatic pixel_sweep(input logic ps);
        int rnd;
        bus_write(6'h31, {4'h0, ps, 3'b000});
        for (int k = 0; k < SWEEP_LEN + 2; k++) begin
            if (k >= 2) begin
                check_val("rgb", 16'({red, green, blue}), 16'(rgb_exp[k-2]));
            end
            if (k < SWEEP_LEN) begin
                rnd          = $random(seed);
                pixel_color4 = rnd[3:0];
                half_bright  = rnd[4];
                // mostly active, some blanking
                active       = rnd[5] | rnd[6];
                rgb_exp[k]   = expected_rgb(pal_model[{ps, rnd[3:0]}], rnd[4], rnd[5] | rnd[6]);
            end
            @(negedge clk_dot4x);
        end
    endtask

    initial begin
        clk_dot4x         = 1'b0;
        rst               = 1'b1;
        bus_strobe        = 1'b0;
        rw                = 1'b1;
        addr              = 6'h00;
        dbi               = 8'h00;
        pixel_color4      = 4'h0;
        half_bright       = 1'b0;
        active            = 1'b0;
        hide_raster_lines = 1'b0;
        seed              = 55148;
        loaded            = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (4) @(negedge clk_dot4x);
        rst = 1'b0;
        check_val("rd_valid", 16'(rd_valid), 16'h0);
        check_val("dbo", 16'(dbo), 16'h0);
        check_val("show_raster_lines", 16'(show_raster_lines), 16'h1);
        check_val("hires_enabled", 16'(hires_enabled), 16'h0);
        check_val("hires_mode", 16'(hires_mode), 16'h0);
        run_vectors();
        fill_palette();
        pixel_sweep(1'b0);
        pixel_sweep(1'b1);
        $display("TB PASSED");
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (vec_count * 6 + 2000) @(posedge clk_dot4x);
        $display("timeout, the test did not finish within %0d cycles", vec_count * 6 + 2000);
        stop_with_failure();
    end

endmodule

`default_nettype wire

// ==== dv/vic_ext_vectors.txt ====
# W addr data | R addr expected_dbo | P pixel_color4 half_bright active expected_rgb
# all fields hex, palette_select comes from mode1 bit 3
R 3f 00
W 3f 20
R 3f 00
R 10 ff
R 00 ff
W 3f 56
W 3f 49
W 3f 41
W 3f 20
R 3f 00
W 3f 56
W 3f 49
W 3f 43
W 3f 32
R 3f 00
W 3f 09
R 3f 09
# pointer 1 writes with increment, pointer 2 reads with decrement
W 39 12
W 3b fe
W 35 03
R 39 12
R 35 03
W 3a a5
R 3b ff
W 3a 5a
R 39 13
R 3b 00
W 3c 13
W 3e 00
W 36 02
R 3d 5a
R 3c 12
R 3e ff
R 3d a5
R 3e fe
# overlay on, pointer 1 increments through the nibbles of entry 1
W 3f 21
R 3f 21
W 39 00
W 3b 04
W 3a 0f
W 3a 08
W 3a 03
W 3a 0c
W 3b 05
W 3a a2
W 3b 04
R 3a 0f
R 3a 02
R 3a 03
R 3a 0c
R 3b 08
# display flags then version, lo steps from 83 to 84
W 3b 83
R 3a 01
R 3a 12
W 3b 83
W 3a 00
W 3b 83
R 3a 00
# mode registers
W 31 fd
R 31 7d
W 32 a6
R 32 a6
# entry 1 of palette 0, then entry 1 of palette 1
W 31 00
P 1 0 1 f23
P 1 1 1 711
P 1 0 0 000
W 3b 44
W 3a 01
W 3a 0e
W 3a 09
W 31 08
P 1 0 1 1e9
P 1 1 1 074
R 31 08

// ==== files.f ====
hw/vic_ext_pkg.sv
hw/reg_bus_ctrl.sv
hw/vram_pointer.sv
hw/color_regs.sv
hw/vic_ext_top.sv
dv/tb_vic_ext.sv

// ==== hw/color_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module color_regs #(
    parameter int PAL_ENTRIES_AW = 5
) (
    input  logic                      clk_dot4x,
    input  logic                      rst,
    input  vic_ext_pkg::clr_op_e      clr_op,
    input  logic [PAL_ENTRIES_AW-1:0] clr_addr,
    input  logic [1:0]                clr_nibble,
    input  logic [3:0]                clr_wdata,
    input  logic                      palette_select,
    input  logic [3:0]                pixel_color4,
    input  logic                      half_bright,
    input  logic                      active,
    output logic [7:0]                clr_rdata,
    output logic [3:0]                red,
    output logic [3:0]                green,
    output logic [3:0]                blue
);
    import vic_ext_pkg::*;

    logic [15:0]               pal [2**PAL_ENTRIES_AW];
    logic [PAL_ENTRIES_AW-1:0] pix_addr;
    logic [15:0]               rmw_word;
    logic [PAL_ENTRIES_AW-1:0] rmw_addr;
    logic                      rmw_pend;
    logic [15:0]               look_word;
    logic                      look_hb;
    logic                      look_act;

    // nibble 0 is red in bits 15:12
    function automatic logic [3:0] get_nibble(input logic [15:0] w, input logic [1:0] n);
        return w[15 - 4*n -: 4];
    endfunction

    function automatic logic [15:0] put_nibble(input logic [15:0] w, input logic [1:0] n,
                                               input logic [3:0] v);
        logic [15:0] r;
        r = w;
        r[15 - 4*n -: 4] = v;
        return r;
    endfunction

    // half bright drops the lowest bit
    function automatic logic [3:0] shade(input logic [3:0] nib, input logic hb);
        return hb ? {1'b0, nib[3:1]} : nib;
    endfunction

    assign pix_addr = {palette_select, pixel_color4};

    // port a, cpu side with read-modify-write
    always_ff @(posedge clk_dot4x) begin
        if (clr_op == CLR_READ) begin
            clr_rdata <= {4'h0, get_nibble(pal[clr_addr], clr_nibble)};
        end
        if (clr_op == CLR_WRITE) begin
            rmw_word <= put_nibble(pal[clr_addr], clr_nibble, clr_wdata);
            rmw_addr <= clr_addr;
        end
        if (rmw_pend) begin
            pal[rmw_addr] <= rmw_word;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            rmw_pend <= 1'b0;
        end else begin
            rmw_pend <= (clr_op == CLR_WRITE);
        end
    end

    // port b, pixel lookup then output stage
    always_ff @(posedge clk_dot4x) begin
        look_word <= pal[pix_addr];
        look_hb   <= half_bright;
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            look_act <= 1'b0;
            red      <= 4'h0;
            green    <= 4'h0;
            blue     <= 4'h0;
        end else begin
            look_act <= active;
            if (look_act) begin
                red   <= shade(look_word[15:12], look_hb);
                green <= shade(look_word[11:8], look_hb);
                blue  <= shade(look_word[7:4], look_hb);
            end else begin
                red   <= 4'h0;
                green <= 4'h0;
                blue  <= 4'h0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/reg_bus_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_bus_ctrl (
    input  logic                          clk_dot4x,
    input  logic                          rst,
    input  logic                          bus_strobe,
    input  logic                          rw,
    input  logic [vic_ext_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    dbi,
    input  logic [7:0]                    mem_rdata,
    input  logic [7:0]                    clr_rdata,
    input  vic_ext_pkg::ext_op_e          ext_op,
    input  logic                          hide_raster_lines,
    output logic [7:0]                    dbo,
    output logic                          rd_valid,
    output vic_ext_pkg::mem_op_e          mem_op,
    output logic                          ptr_sel,
    output logic [7:0]                    mem_wdata,
    output vic_ext_pkg::step_e            step1,
    output vic_ext_pkg::step_e            step2,
    output logic                          overlay,
    output logic                          palette_select,
    output logic                          show_raster_lines,
    output logic                          hires_enabled,
    output logic [1:0]                    hires_mode,
    output logic [2:0]                    hires_char_pixel_base,
    output logic [3:0]                    hires_matrix_base,
    output logic [3:0]                    hires_color_base
);
    import vic_ext_pkg::*;

    reg_addr_e     addr_e;
    unlock_state_e unlock_st;
    logic [7:0]    flags;
    mem_op_e       op_d;
    logic          sel_d;
    logic [7:0]    ctrl_rd;
    // read pipeline, stage 1 holds cycle T+1, stage 2 cycle T+2
    logic          src_ctrl1;
    logic          src_mem1;
    logic [7:0]    ctrl_val1;
    logic          src_ctrl2;
    logic          src_mem2;
    logic          src_clr2;
    logic [7:0]    ctrl_val2;

    assign addr_e  = reg_addr_e'(addr);
    assign step1   = step_e'(flags[1:0]);
    assign step2   = step_e'(flags[3:2]);
    assign overlay = flags[OVERLAY_BIT];

    // address decode
    always_comb begin
        op_d  = MEM_NONE;
        sel_d = addr_e inside {REG_MEM2_HI, REG_MEM2_LO, REG_MEM2_IDX, REG_MEM2_VAL};
        case (addr_e)
            REG_MEM1_HI, REG_MEM2_HI:   op_d = rw ? MEM_RD_HI : MEM_WR_HI;
            REG_MEM1_LO, REG_MEM2_LO:   op_d = rw ? MEM_RD_LO : MEM_WR_LO;
            REG_MEM1_IDX, REG_MEM2_IDX: op_d = rw ? MEM_RD_IDX : MEM_WR_IDX;
            REG_MEM1_VAL, REG_MEM2_VAL: op_d = rw ? MEM_RD_VAL : MEM_WR_VAL;
            default:                    op_d = MEM_NONE;
        endcase
        case (addr_e)
            REG_MODE1: ctrl_rd = {1'b0, hires_mode, hires_enabled, palette_select,
                                  hires_char_pixel_base};
            REG_MODE2: ctrl_rd = {hires_color_base, hires_matrix_base};
            REG_FLAGS: ctrl_rd = flags;
            default:   ctrl_rd = 8'hFF;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            unlock_st             <= ST_IDLE;
            flags                 <= 8'h00;
            hires_mode            <= 2'b00;
            hires_enabled         <= 1'b0;
            palette_select        <= 1'b0;
            hires_char_pixel_base <= 3'b000;
            hires_matrix_base     <= 4'h0;
            hires_color_base      <= 4'h0;
            mem_op                <= MEM_NONE;
            ptr_sel               <= 1'b0;
            src_ctrl1             <= 1'b0;
            src_mem1              <= 1'b0;
        end else begin
            mem_op    <= bus_strobe ? op_d : MEM_NONE;
            src_ctrl1 <= bus_strobe && rw && (op_d == MEM_NONE);
            src_mem1  <= bus_strobe && rw && (op_d != MEM_NONE);
            if (bus_strobe) begin
                ptr_sel <= sel_d;
            end
            if (bus_strobe && !rw) begin
                case (addr_e)
                    REG_MODE1: begin
                        hires_mode            <= dbi[6:5];
                        hires_enabled         <= dbi[4];
                        palette_select        <= dbi[3];
                        hires_char_pixel_base <= dbi[2:0];
                    end
                    REG_MODE2: begin
                        hires_color_base  <= dbi[7:4];
                        hires_matrix_base <= dbi[3:0];
                    end
                    REG_FLAGS: begin
                        // a wrong byte anywhere restarts the sequence
                        case (unlock_st)
                            ST_IDLE:  unlock_st <= (dbi == UNLOCK_V) ? ST_GOT_V : ST_IDLE;
                            ST_GOT_V: unlock_st <= (dbi == UNLOCK_I) ? ST_GOT_I : ST_IDLE;
                            ST_GOT_I: unlock_st <= (dbi == UNLOCK_C) ? ST_GOT_C : ST_IDLE;
                            ST_GOT_C: unlock_st <= (dbi == UNLOCK_2) ? ST_UNLOCKED : ST_IDLE;
                            default:  flags <= dbi;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    // data for the datapath and control values of a read
    always_ff @(posedge clk_dot4x) begin
        if (bus_strobe) begin
            mem_wdata <= dbi;
            ctrl_val1 <= ctrl_rd;
        end
        case (ext_op)
            EXT_RD_FLAGS:   ctrl_val2 <= {7'b0, show_raster_lines};
            EXT_RD_VERSION: ctrl_val2 <= VERSION_BYTE;
            default:        ctrl_val2 <= ctrl_val1;
        endcase
    end

    // stage 2, value reads are routed by ext_op from the pointer block
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            src_ctrl2         <= 1'b0;
            src_mem2          <= 1'b0;
            src_clr2          <= 1'b0;
            rd_valid          <= 1'b0;
            show_raster_lines <= ~hide_raster_lines;
        end else begin
            src_ctrl2 <= src_ctrl1 ||
                         (src_mem1 && (ext_op inside {EXT_RD_FLAGS, EXT_RD_VERSION}));
            src_mem2  <= src_mem1 && (ext_op == EXT_NONE);
            src_clr2  <= src_mem1 && (ext_op == EXT_NOP);
            rd_valid  <= src_ctrl1 || src_mem1;
            if (ext_op == EXT_WR_FLAGS) begin
                show_raster_lines <= mem_wdata[0];
            end
        end
    end

    always_comb begin
        dbo = 8'h00;
        if (src_ctrl2) begin
            dbo = ctrl_val2;
        end else if (src_mem2) begin
            dbo = mem_rdata;
        end else if (src_clr2) begin
            dbo = clr_rdata;
        end
    end

    // the bus has no back-pressure, strobes stay 4 cycles apart
    a_strobe_spacing: assert property (@(posedge clk_dot4x) disable iff (rst)
        bus_strobe |=> !bus_strobe [*3]);

    // each read ends in exactly one source
    a_one_source: assert property (@(posedge clk_dot4x) disable iff (rst)
        rd_valid |-> $onehot({src_ctrl2, src_mem2, src_clr2}));

endmodule

`default_nettype wire

// ==== hw/vic_ext_pkg.sv ====
`default_nettype none

package vic_ext_pkg;

    localparam int ADDR_W = 6;

    // cpu register addresses that survive in this block
    typedef enum logic [ADDR_W-1:0] {
        REG_MODE1    = 6'h31,
        REG_MODE2    = 6'h32,
        REG_MEM1_IDX = 6'h35,
        REG_MEM2_IDX = 6'h36,
        REG_MEM1_HI  = 6'h39,
        REG_MEM1_VAL = 6'h3A,
        REG_MEM1_LO  = 6'h3B,
        REG_MEM2_HI  = 6'h3C,
        REG_MEM2_VAL = 6'h3D,
        REG_MEM2_LO  = 6'h3E,
        REG_FLAGS    = 6'h3F
    } reg_addr_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_GOT_V,
        ST_GOT_I,
        ST_GOT_C,
        ST_UNLOCKED
    } unlock_state_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_WR_HI,
        MEM_WR_LO,
        MEM_WR_IDX,
        MEM_RD_HI,
        MEM_RD_LO,
        MEM_RD_IDX,
        MEM_RD_VAL,
        MEM_WR_VAL
    } mem_op_e;

    // code 3 behaves like hold
    typedef enum logic [1:0] {
        STEP_HOLD = 2'd0,
        STEP_INC  = 2'd1,
        STEP_DEC  = 2'd2
    } step_e;

    typedef enum logic [1:0] {
        CLR_NONE,
        CLR_READ,
        CLR_WRITE
    } clr_op_e;

    // nop marks an overlay access served by the color registers
    typedef enum logic [2:0] {
        EXT_NONE,
        EXT_RD_FLAGS,
        EXT_WR_FLAGS,
        EXT_RD_VERSION,
        EXT_NOP
    } ext_op_e;

    localparam logic [7:0] EXT_DISPLAY_FLAGS = 8'h83;
    localparam logic [7:0] EXT_VERSION       = 8'h84;
    localparam logic [7:0] VERSION_BYTE      = 8'h12;
    localparam logic [2:0] OVERLAY_BIT       = 3'd5;

    // "VIC2" written to the flags register
    localparam logic [7:0] UNLOCK_V = 8'd86;
    localparam logic [7:0] UNLOCK_I = 8'd73;
    localparam logic [7:0] UNLOCK_C = 8'd67;
    localparam logic [7:0] UNLOCK_2 = 8'd50;

endpackage

`default_nettype wire

// ==== hw/vic_ext_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module vic_ext_top #(
    parameter int VRAM_AW        = 15,
    parameter int PAL_ENTRIES_AW = 5
) (
    input  logic                          clk_dot4x,
    input  logic                          rst,
    input  logic                          bus_strobe,
    input  logic                          rw,
    input  logic [vic_ext_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    dbi,
    output logic [7:0]                    dbo,
    output logic                          rd_valid,
    input  logic [3:0]                    pixel_color4,
    input  logic                          half_bright,
    input  logic                          active,
    output logic [3:0]                    red,
    output logic [3:0]                    green,
    output logic [3:0]                    blue,
    input  logic                          hide_raster_lines,
    output logic                          show_raster_lines,
    output logic                          hires_enabled,
    output logic [1:0]                    hires_mode,
    output logic [2:0]                    hires_char_pixel_base,
    output logic [3:0]                    hires_matrix_base,
    output logic [3:0]                    hires_color_base
);
    import vic_ext_pkg::*;

    mem_op_e                   mem_op;
    logic                      ptr_sel;
    logic [7:0]                mem_wdata;
    step_e                     step1;
    step_e                     step2;
    logic                      overlay;
    logic                      palette_select;
    logic [7:0]                mem_rdata;
    ext_op_e                   ext_op;
    clr_op_e                   clr_op;
    logic [PAL_ENTRIES_AW-1:0] clr_addr;
    logic [1:0]                clr_nibble;
    logic [3:0]                clr_wdata;
    logic [7:0]                clr_rdata;

    reg_bus_ctrl u_ctrl (
        .clk_dot4x             (clk_dot4x),
        .rst                   (rst),
        .bus_strobe            (bus_strobe),
        .rw                    (rw),
        .addr                  (addr),
        .dbi                   (dbi),
        .mem_rdata             (mem_rdata),
        .clr_rdata             (clr_rdata),
        .ext_op                (ext_op),
        .hide_raster_lines     (hide_raster_lines),
        .dbo                   (dbo),
        .rd_valid              (rd_valid),
        .mem_op                (mem_op),
        .ptr_sel               (ptr_sel),
        .mem_wdata             (mem_wdata),
        .step1                 (step1),
        .step2                 (step2),
        .overlay               (overlay),
        .palette_select        (palette_select),
        .show_raster_lines     (show_raster_lines),
        .hires_enabled         (hires_enabled),
        .hires_mode            (hires_mode),
        .hires_char_pixel_base (hires_char_pixel_base),
        .hires_matrix_base     (hires_matrix_base),
        .hires_color_base      (hires_color_base)
    );

    vram_pointer #(.VRAM_AW(VRAM_AW)) u_vram (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .mem_op     (mem_op),
        .ptr_sel    (ptr_sel),
        .mem_wdata  (mem_wdata),
        .step1      (step1),
        .step2      (step2),
        .overlay    (overlay),
        .mem_rdata  (mem_rdata),
        .ext_op     (ext_op),
        .clr_op     (clr_op),
        .clr_addr   (clr_addr),
        .clr_nibble (clr_nibble),
        .clr_wdata  (clr_wdata)
    );

    color_regs #(.PAL_ENTRIES_AW(PAL_ENTRIES_AW)) u_color (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .clr_op         (clr_op),
        .clr_addr       (clr_addr),
        .clr_nibble     (clr_nibble),
        .clr_wdata      (clr_wdata),
        .palette_select (palette_select),
        .pixel_color4   (pixel_color4),
        .half_bright    (half_bright),
        .active         (active),
        .clr_rdata      (clr_rdata),
        .red            (red),
        .green          (green),
        .blue           (blue)
    );

endmodule

`default_nettype wire

// ==== hw/vram_pointer.sv ====
`timescale 1ns/1ns
`default_nettype none

module vram_pointer #(
    parameter int VRAM_AW = 15
) (
    input  logic                 clk_dot4x,
    input  logic                 rst,
    input  vic_ext_pkg::mem_op_e mem_op,
    input  logic                 ptr_sel,
    input  logic [7:0]           mem_wdata,
    input  vic_ext_pkg::step_e   step1,
    input  vic_ext_pkg::step_e   step2,
    input  logic                 overlay,
    output logic [7:0]           mem_rdata,
    output vic_ext_pkg::ext_op_e ext_op,
    output vic_ext_pkg::clr_op_e clr_op,
    output logic [4:0]           clr_addr,
    output logic [1:0]           clr_nibble,
    output logic [3:0]           clr_wdata
);
    import vic_ext_pkg::*;

    logic [7:0]         hi [2];
    logic [7:0]         lo [2];
    logic [7:0]         idx [2];
    logic [7:0]         vram [2**VRAM_AW];
    logic [7:0]         cur_lo;
    logic [15:0]        addr_sum;
    logic [VRAM_AW-1:0] vram_addr;
    logic               val_acc;
    logic               val_rd;
    logic               to_clr;
    logic               to_ext;
    logic               ram_we;
    logic               step_pend;
    logic               step_ptr;
    step_e              step_mode;
    logic [15:0]        pair;

    assign cur_lo    = lo[ptr_sel];
    assign addr_sum  = {1'b0, hi[ptr_sel][6:0], cur_lo} + {8'h00, idx[ptr_sel]};
    assign vram_addr = addr_sum[VRAM_AW-1:0];
    assign val_rd    = (mem_op == MEM_RD_VAL);
    assign val_acc   = val_rd || (mem_op == MEM_WR_VAL);

    // overlay routing on lo
    assign to_clr = overlay && (cur_lo < 8'h80);
    assign to_ext = overlay && ((cur_lo == EXT_DISPLAY_FLAGS) || (cur_lo == EXT_VERSION));
    assign ram_we = (mem_op == MEM_WR_VAL) && !to_clr && !to_ext;

    assign clr_op     = (val_acc && to_clr) ? (val_rd ? CLR_READ : CLR_WRITE) : CLR_NONE;
    assign clr_addr   = cur_lo[6:2];
    assign clr_nibble = cur_lo[1:0];
    assign clr_wdata  = mem_wdata[3:0];

    always_comb begin
        ext_op = EXT_NONE;
        if (val_acc && to_clr) begin
            ext_op = EXT_NOP;
        end else if (val_acc && to_ext) begin
            if (cur_lo == EXT_DISPLAY_FLAGS) begin
                ext_op = val_rd ? EXT_RD_FLAGS : EXT_WR_FLAGS;
            end else if (val_rd) begin
                // version is read only
                ext_op = EXT_RD_VERSION;
            end
        end
    end

    assign step_mode = step_ptr ? step2 : step1;
    assign pair      = {hi[step_ptr], lo[step_ptr]};

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int i = 0; i < 2; i++) begin
                hi[i]  <= 8'h00;
                lo[i]  <= 8'h00;
                idx[i] <= 8'h00;
            end
            step_pend <= 1'b0;
            step_ptr  <= 1'b0;
        end else begin
            step_pend <= val_acc;
            step_ptr  <= ptr_sel;
            case (mem_op)
                MEM_WR_HI:  hi[ptr_sel]  <= mem_wdata;
                MEM_WR_LO:  lo[ptr_sel]  <= mem_wdata;
                MEM_WR_IDX: idx[ptr_sel] <= mem_wdata;
                default: ;
            endcase
            // step one cycle after the value access
            if (step_pend) begin
                case (step_mode)
                    STEP_INC: {hi[step_ptr], lo[step_ptr]} <= pair + 16'd1;
                    STEP_DEC: {hi[step_ptr], lo[step_ptr]} <= pair - 16'd1;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (ram_we) begin
            vram[vram_addr] <= mem_wdata;
        end
        case (mem_op)
            MEM_RD_HI:  mem_rdata <= hi[ptr_sel];
            MEM_RD_LO:  mem_rdata <= cur_lo;
            MEM_RD_IDX: mem_rdata <= idx[ptr_sel];
            default:    mem_rdata <= vram[vram_addr];
        endcase
    end

    // the palette write back cycle carries no other access
    a_clr_xor_ram: assert property (@(posedge clk_dot4x) disable iff (rst)
        (clr_op == CLR_WRITE) |=> (clr_op == CLR_NONE) && !ram_we);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_vic_ext -f files.f -o sim_vic_ext

# a failing run exits non-zero, the verdict comes from the output
output=$(./obj_dir/sim_vic_ext 2>&1 || true)
echo "$output"
grep -qx "TB PASSED" <<< "$output"
